// ==== source/gpuTexPkg.sv ====
/*
 Shared types and cache geometry of the texture stage
*/
package gpuTexPkg;

	// --------------------
	// Geometry
	// --------------------
	// VRAM is addressed in halfwords
	localparam int vramAddrBits = 19;
	localparam int texLines = 64;
	localparam int texWordsPerLine = 4;
	localparam int texLineBits = $clog2(texLines);
	localparam int texWordBits = $clog2(texWordsPerLine);
	localparam int texTagBits = vramAddrBits - texLineBits - texWordBits;
	// CLUT base is 9 row bits and 6 column bits in 16-colour units
	localparam int clutAddrBits = 15;
	localparam int clutLines = 16;
	localparam int clutWordsPerLine = 16;
	localparam int clutLineBits = $clog2(clutLines);
	localparam int clutWordBits = $clog2(clutWordsPerLine);
	localparam int clutTagBits = clutAddrBits - clutLineBits;
	// Widest line address, a texture halfword address without its word bits
	localparam int lineAddrBits = vramAddrBits - texWordBits;
	localparam logic [15:0] untexturedColor = 16'h7FFF;

	// --------------------
	// Types
	// --------------------
	typedef enum logic [1:0] {
		fmtPal4 = 2'd0,
		fmtPal8 = 2'd1,
		fmtDirect15 = 2'd2
	} texFormat_t;

	typedef enum logic {
		fillTex,
		fillClut
	} fillKind_t;

	typedef struct packed {
		logic [9:0] scrX;
		logic [8:0] scrY;
		logic [8:0] r;
		logic [8:0] g;
		logic [8:0] b;
		logic bgMask;
		logic [1:0] uLsb;
		logic [vramAddrBits-1:0] texAddr;
	} pixelIn_t;

	typedef struct packed {
		logic [9:0] scrX;
		logic [8:0] scrY;
		logic [8:0] r;
		logic [8:0] g;
		logic [8:0] b;
		logic bgMask;
		logic [15:0] texel;
		logic transparent;
	} pixelOut_t;

	typedef struct packed {
		fillKind_t kind;
		logic [lineAddrBits-1:0] lineAddr;
	} fillReq_t;

	typedef struct packed {
		fillKind_t kind;
		logic [lineAddrBits-1:0] lineAddr;
		logic [clutWordBits-1:0] wordIdx;
		logic [15:0] data;
	} fillWrite_t;

	// CLUT line holding a palette index, column wraps inside the row
	function automatic logic [clutAddrBits-1:0] clutLineOf(
		logic [clutAddrBits-1:0] base,
		logic [7:0] index
	);
		return {base[clutAddrBits-1:6], base[5:0] + {2'b00, index[7:4]}};
	endfunction

endpackage

// ==== source/texelToIndex.sv ====
/*
 Palette index decoder, picks a nibble or a byte of a texel halfword
*/
module texelToIndex (
	input gpuTexPkg::texFormat_t texFormat,
	input logic [15:0] texel,
	input logic [1:0] uLsb,
	output logic [7:0] index
);
	import gpuTexPkg::*;

	always_comb begin
		case (texFormat)
			// Four texels per halfword, low U bits pick the nibble
			fmtPal4: begin
				index = {4'h0, texel[{uLsb, 2'b00} +: 4]};
			end
			// Two texels per halfword
			fmtPal8: begin
				index = texel[{uLsb[0], 3'b000} +: 8];
			end
			// Direct colour has no index
			default: begin
				index = 8'h00;
			end
		endcase
	end

endmodule

// ==== source/texCache.sv ====
/*
 Direct-mapped texture cache of 4-halfword lines
 Address registered in stage 0, hit or miss and data in stage 1
*/
module texCache (
	input logic clk,
	input logic rstN,
	input logic [gpuTexPkg::vramAddrBits-1:0] lookupAddr,
	input logic lookupEn,
	input logic stall,
	output logic hit,
	output logic miss,
	output logic [15:0] data,
	input gpuTexPkg::fillWrite_t fill,
	input logic fillWe,
	input logic fillDone
);
	import gpuTexPkg::*;

	logic [15:0] mem [texLines*texWordsPerLine];
	logic [texTagBits-1:0] tags [texLines];
	logic [texLines-1:0] lineValid;
	logic [vramAddrBits-1:0] addrQ;
	logic enQ;
	logic [texLineBits-1:0] lineSel;
	logic tagMatch;
	logic fillHere;
	logic [texLineBits-1:0] fillLine;

	// --------------------
	// Lookup
	// --------------------
	// Address frozen while the pipeline is stalled
	always_ff @(posedge clk) begin
		if (!stall) begin
			addrQ <= lookupAddr;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			enQ <= 1'b0;
		end else if (!stall) begin
			enQ <= lookupEn;
		end
	end

	assign lineSel = addrQ[texWordBits +: texLineBits];
	assign tagMatch = lineValid[lineSel] && (tags[lineSel] == addrQ[vramAddrBits-1 -: texTagBits]);
	assign hit = enQ & tagMatch;
	assign miss = enQ & !tagMatch;
	assign data = mem[addrQ[texLineBits+texWordBits-1:0]];

	// --------------------
	// Fill
	// --------------------
	assign fillHere = fill.kind == fillTex;
	assign fillLine = fill.lineAddr[texLineBits-1:0];

	always_ff @(posedge clk) begin
		if (fillWe && fillHere) begin
			mem[{fillLine, fill.wordIdx[texWordBits-1:0]}] <= fill.data;
		end
		if (fillDone && fillHere) begin
			tags[fillLine] <= fill.lineAddr[lineAddrBits-1 -: texTagBits];
		end
	end

	// Line is invalid while being overwritten, valid again on done
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lineValid <= '0;
		end else begin
			if (fillWe && fillHere) begin
				lineValid[fillLine] <= 1'b0;
			end
			if (fillDone && fillHere) begin
				lineValid[fillLine] <= 1'b1;
			end
		end
	end

	// Missing lookup stays frozen upstream until its own fill ends
	missHeld: assert property (@(posedge clk) disable iff (!rstN)
		miss && !(fillDone && fillHere) |=> miss);

endmodule

// ==== source/clutCache.sv ====
/*
 Direct-mapped palette cache of 16-colour lines
 Hit and miss in the lookup cycle, colour registered for the next stage
*/
module clutCache (
	input logic clk,
	input logic rstN,
	input logic [gpuTexPkg::clutAddrBits-1:0] clutBase,
	input logic [7:0] index,
	input logic lookupEn,
	input logic stall,
	output logic hit,
	output logic miss,
	output logic [15:0] data,
	input gpuTexPkg::fillWrite_t fill,
	input logic fillWe,
	input logic fillDone
);
	import gpuTexPkg::*;

	logic [15:0] mem [clutLines*clutWordsPerLine];
	logic [clutTagBits-1:0] tags [clutLines];
	logic [clutLines-1:0] lineValid;
	logic [clutAddrBits-1:0] lineAddr;
	logic [clutLineBits-1:0] slot;
	logic tagMatch;
	logic fillHere;
	logic [clutLineBits-1:0] fillSlot;

	// Row joined with column plus the high index nibble
	assign lineAddr = clutLineOf(clutBase, index);
	assign slot = lineAddr[clutLineBits-1:0];
	assign tagMatch = lineValid[slot] && (tags[slot] == lineAddr[clutAddrBits-1:clutLineBits]);
	assign hit = lookupEn & tagMatch;
	assign miss = lookupEn & !tagMatch;

	// Colour for stage 2, held through a stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			data <= mem[{slot, index[clutWordBits-1:0]}];
		end
	end

	// --------------------
	// Fill
	// --------------------
	assign fillHere = fill.kind == fillClut;
	assign fillSlot = fill.lineAddr[clutLineBits-1:0];

	always_ff @(posedge clk) begin
		if (fillWe && fillHere) begin
			mem[{fillSlot, fill.wordIdx}] <= fill.data;
		end
		if (fillDone && fillHere) begin
			tags[fillSlot] <= fill.lineAddr[clutAddrBits-1:clutLineBits];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lineValid <= '0;
		end else begin
			if (fillWe && fillHere) begin
				lineValid[fillSlot] <= 1'b0;
			end
			if (fillDone && fillHere) begin
				lineValid[fillSlot] <= 1'b1;
			end
		end
	end

	// Pipeline keeps the palette lookup alive while its line is fetched
	lookupHeld: assert property (@(posedge clk) disable iff (!rstN) miss |=> lookupEn);

endmodule

// ==== source/pixelPipeCtrl.sv ====
/*
 Three-stage pixel pipeline, issues cache lookups and freezes on a miss
 Stage 2 forms the final texel and the transparency flag
*/
module pixelPipeCtrl (
	input logic clk,
	input logic rstN,
	input gpuTexPkg::texFormat_t texFormat,
	input logic [gpuTexPkg::clutAddrBits-1:0] clutBase,
	input logic texDisable,
	input logic pixelValid,
	input gpuTexPkg::pixelIn_t pixelIn,
	output logic pixelReady,
	output logic [gpuTexPkg::vramAddrBits-1:0] texLookupAddr,
	output logic texLookupEn,
	input logic texHit,
	input logic texMiss,
	input logic [15:0] texData,
	output logic [7:0] clutIndex,
	output logic clutLookupEn,
	input logic clutHit,
	input logic clutMiss,
	input logic [15:0] clutData,
	output logic fillReqValid,
	output gpuTexPkg::fillReq_t fillReq,
	input logic fillBusy,
	input logic fillDone,
	output logic outValid,
	output gpuTexPkg::pixelOut_t pixelOut,
	output logic busy
);
	import gpuTexPkg::*;

	logic stall;
	logic isPalette;
	logic reqPending;
	logic s1Valid;
	logic s1Textured;
	pixelIn_t s1Pix;
	logic s2Valid;
	logic s2Textured;
	logic s2FromClut;
	pixelIn_t s2Pix;
	logic [15:0] s2TexData;
	logic [15:0] texel;

	// Any miss or running fill stops every stage
	assign stall = texMiss | clutMiss | fillBusy;
	assign pixelReady = !stall;
	assign isPalette = texFormat != fmtDirect15;
	assign busy = s1Valid | s2Valid;

	// --------------------
	// Stage 0
	// --------------------
	assign texLookupAddr = pixelIn.texAddr;
	assign texLookupEn = pixelValid & !texDisable;

	// --------------------
	// Stage 1
	// --------------------
	texelToIndex uIndex (
		.texFormat(texFormat),
		.texel(texData),
		.uLsb(s1Pix.uLsb),
		.index(clutIndex)
	);

	// Palette lookup only once the texel itself is known
	assign clutLookupEn = s1Textured & isPalette & texHit;

	// One request per miss, texture misses come first
	assign fillReqValid = (texMiss | clutMiss) & !reqPending;

	always_comb begin
		if (texMiss) begin
			fillReq.kind = fillTex;
			fillReq.lineAddr = s1Pix.texAddr[vramAddrBits-1:texWordBits];
		end else begin
			fillReq.kind = fillClut;
			fillReq.lineAddr = lineAddrBits'(clutLineOf(clutBase, clutIndex));
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqPending <= 1'b0;
		end else if (fillDone) begin
			reqPending <= 1'b0;
		end else if (fillReqValid) begin
			reqPending <= 1'b1;
		end
	end

	// --------------------
	// Stage registers
	// --------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s1Textured <= 1'b0;
			s2Valid <= 1'b0;
			s2Textured <= 1'b0;
			s2FromClut <= 1'b0;
		end else begin
			// A bubble enters stage 2 on a stall so nothing is output twice
			s2Valid <= s1Valid & !stall;
			if (!stall) begin
				s1Valid <= pixelValid;
				s1Textured <= pixelValid & !texDisable;
				s2Textured <= s1Textured;
				s2FromClut <= clutHit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s1Pix <= pixelIn;
			s2Pix <= s1Pix;
			s2TexData <= texData;
		end
	end

	// --------------------
	// Stage 2
	// --------------------
	always_comb begin
		if (!s2Textured) begin
			texel = untexturedColor;
		end else if (s2FromClut) begin
			texel = clutData;
		end else begin
			texel = s2TexData;
		end
	end

	assign outValid = s2Valid;

	always_comb begin
		pixelOut.scrX = s2Pix.scrX;
		pixelOut.scrY = s2Pix.scrY;
		pixelOut.r = s2Pix.r;
		pixelOut.g = s2Pix.g;
		pixelOut.b = s2Pix.b;
		pixelOut.bgMask = s2Pix.bgMask;
		pixelOut.texel = texel;
		// All-zero colour means see-through, bit 15 excluded
		pixelOut.transparent = (texel[14:0] == 15'd0) & !texDisable;
	end

	// A palette pixel leaves only with the colour its CLUT lookup returned
	paletteFromClut: assert property (@(posedge clk) disable iff (!rstN)
		outValid && s2Textured && isPalette |-> s2FromClut);

endmodule

// ==== source/cacheFillApb.sv ====
/*
 Cache line fill over an APB master port
 One miss becomes 4 or 16 sequential halfword reads
*/
module cacheFillApb (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input gpuTexPkg::fillReq_t req,
	output logic busy,
	output logic fillWe,
	output gpuTexPkg::fillWrite_t fill,
	output logic fillDone,
	output logic [gpuTexPkg::vramAddrBits-1:0] paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	input logic pready,
	input logic [15:0] prdata,
	input logic pslverr
);
	import gpuTexPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stSetup,
		stAccess,
		stDone
	} fillState_t;

	fillState_t state;
	fillReq_t reqQ;
	logic [clutWordBits-1:0] wordIdx;
	logic [clutWordBits-1:0] lastIdx;
	logic [vramAddrBits-1:0] baseAddr;

	// Line base in halfwords and burst length per target cache
	always_comb begin
		if (reqQ.kind == fillTex) begin
			baseAddr = {reqQ.lineAddr, {texWordBits{1'b0}}};
			lastIdx = clutWordBits'(texWordsPerLine - 1);
		end else begin
			baseAddr = {reqQ.lineAddr[clutAddrBits-1:0], {clutWordBits{1'b0}}};
			lastIdx = clutWordBits'(clutWordsPerLine - 1);
		end
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && reqValid) begin
			reqQ <= req;
		end
	end

	// --------------------
	// FSM
	// --------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			wordIdx <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (reqValid) begin
						state <= stSetup;
						wordIdx <= '0;
					end
				end
				stSetup: begin
					state <= stAccess;
				end
				stAccess: begin
					// Back to setup between reads, per APB
					if (pready && wordIdx == lastIdx) begin
						state <= stDone;
					end else if (pready) begin
						state <= stSetup;
						wordIdx <= wordIdx + 1'b1;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	assign busy = state != stIdle;
	assign psel = (state == stSetup) || (state == stAccess);
	assign penable = state == stAccess;
	// Read only port
	assign pwrite = 1'b0;
	assign paddr = baseAddr + {{(vramAddrBits-clutWordBits){1'b0}}, wordIdx};
	assign fillWe = penable & pready;
	assign fillDone = state == stDone;

	always_comb begin
		fill.kind = reqQ.kind;
		fill.lineAddr = reqQ.lineAddr;
		fill.wordIdx = wordIdx;
		fill.data = prdata;
	end

	// Address holds through the whole access phase
	apbAddrStable: assert property (@(posedge clk) disable iff (!rstN)
		penable |-> $stable(paddr));

endmodule

// ==== source/texPixelTop.sv ====
/*
 Texture stage top, pipeline with texture and palette caches
 Cache misses are filled from VRAM over APB
*/
module texPixelTop (
	input logic clk,
	input logic rstN,
	input gpuTexPkg::texFormat_t texFormat,
	input logic [gpuTexPkg::clutAddrBits-1:0] clutBase,
	input logic texDisable,
	input logic pixelValid,
	input gpuTexPkg::pixelIn_t pixelIn,
	output logic pixelReady,
	output logic outValid,
	output gpuTexPkg::pixelOut_t pixelOut,
	output logic busy,
	output logic [gpuTexPkg::vramAddrBits-1:0] paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	input logic pready,
	input logic [15:0] prdata,
	input logic pslverr
);
	import gpuTexPkg::*;

	logic [vramAddrBits-1:0] texLookupAddr;
	logic texLookupEn;
	logic texHit;
	logic texMiss;
	logic [15:0] texData;
	logic [7:0] clutIndex;
	logic clutLookupEn;
	logic clutHit;
	logic clutMiss;
	logic [15:0] clutData;
	logic fillReqValid;
	fillReq_t fillReq;
	logic fillBusy;
	logic fillWe;
	fillWrite_t fill;
	logic fillDone;

	pixelPipeCtrl uPipe (
		.clk(clk),
		.rstN(rstN),
		.texFormat(texFormat),
		.clutBase(clutBase),
		.texDisable(texDisable),
		.pixelValid(pixelValid),
		.pixelIn(pixelIn),
		.pixelReady(pixelReady),
		.texLookupAddr(texLookupAddr),
		.texLookupEn(texLookupEn),
		.texHit(texHit),
		.texMiss(texMiss),
		.texData(texData),
		.clutIndex(clutIndex),
		.clutLookupEn(clutLookupEn),
		.clutHit(clutHit),
		.clutMiss(clutMiss),
		.clutData(clutData),
		.fillReqValid(fillReqValid),
		.fillReq(fillReq),
		.fillBusy(fillBusy),
		.fillDone(fillDone),
		.outValid(outValid),
		.pixelOut(pixelOut),
		.busy(busy)
	);

	// Caches freeze exactly when the pipeline refuses input
	texCache uTexCache (
		.clk(clk),
		.rstN(rstN),
		.lookupAddr(texLookupAddr),
		.lookupEn(texLookupEn),
		.stall(!pixelReady),
		.hit(texHit),
		.miss(texMiss),
		.data(texData),
		.fill(fill),
		.fillWe(fillWe),
		.fillDone(fillDone)
	);

	clutCache uClutCache (
		.clk(clk),
		.rstN(rstN),
		.clutBase(clutBase),
		.index(clutIndex),
		.lookupEn(clutLookupEn),
		.stall(!pixelReady),
		.hit(clutHit),
		.miss(clutMiss),
		.data(clutData),
		.fill(fill),
		.fillWe(fillWe),
		.fillDone(fillDone)
	);

	cacheFillApb uFill (
		.clk(clk),
		.rstN(rstN),
		.reqValid(fillReqValid),
		.req(fillReq),
		.busy(fillBusy),
		.fillWe(fillWe),
		.fill(fill),
		.fillDone(fillDone),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr)
	);

endmodule

// ==== testbench/pixelChecker.sv ====
/*
 Texture stage checker, models the expected pixel of every accepted input
 Compares values, latency, busy and the APB fill bursts
*/
module pixelChecker (
	input logic clk,
	input logic rstN,
	input gpuTexPkg::texFormat_t texFormat,
	input logic [gpuTexPkg::clutAddrBits-1:0] clutBase,
	input logic texDisable,
	input logic pixelValid,
	input gpuTexPkg::pixelIn_t pixelIn,
	input logic pixelReady,
	input logic outValid,
	input gpuTexPkg::pixelOut_t pixelOut,
	input logic busy,
	input logic [gpuTexPkg::vramAddrBits-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	output int valueErrors,
	output int timingErrors,
	output int protocolErrors,
	output int acceptCount,
	output int outCount
);
	timeunit 1ns;
	timeprecision 100ps;
	import gpuTexPkg::*;

	typedef struct packed {
		pixelOut_t exp;
		logic [1:0] testId;
		int acceptCycle;
		int stallMark;
	} entry_t;

	entry_t pending[$];
	int cycle;
	int stallCount;
	int burstWords;
	logic [vramAddrBits-1:0] burstBase;

	// --------------------
	// Reference model
	// --------------------
	// VRAM contents, same pattern as the memory model
	function automatic logic [15:0] vramWord(input logic [18:0] addr);
		logic [14:0] mixed;
		mixed = addr[14:0] ^ {addr[18:15], 11'h000} ^ 15'h1234;
		return {addr[3], mixed};
	endfunction

	function automatic pixelOut_t expectedPixel(
		input pixelIn_t pix,
		input texFormat_t fmt,
		input logic [14:0] base,
		input logic untextured
	);
		logic [15:0] word;
		logic [7:0] index;
		logic [5:0] column;
		logic [15:0] texel;
		pixelOut_t result;
		word = vramWord(pix.texAddr);
		if (untextured) begin
			texel = 16'h7FFF;
		end else if (fmt == fmtDirect15) begin
			texel = word;
		end else begin
			// Nibble or byte of the halfword picked by the low U bits
			if (fmt == fmtPal4) begin
				index = 8'((word >> {pix.uLsb, 2'b00}) & 16'h000F);
			end else begin
				index = 8'(word >> {pix.uLsb[0], 3'b000});
			end
			// Column wraps inside the CLUT row
			column = base[5:0] + {2'b00, index[7:4]};
			texel = vramWord({base[14:6], column, index[3:0]});
		end
		result.scrX = pix.scrX;
		result.scrY = pix.scrY;
		result.r = pix.r;
		result.g = pix.g;
		result.b = pix.b;
		result.bgMask = pix.bgMask;
		result.texel = texel;
		result.transparent = !untextured && (texel[14:0] == 15'd0);
		return result;
	endfunction

	function automatic logic [1:0] testIdOf(input texFormat_t fmt, input logic untextured);
		if (untextured) begin
			return 2'd0;
		end
		case (fmt)
			fmtDirect15: return 2'd1;
			fmtPal4: return 2'd2;
			default: return 2'd3;
		endcase
	endfunction

	function automatic string testName(input logic [1:0] id);
		case (id)
			2'd0: return "untextured";
			2'd1: return "direct15";
			2'd2: return "pal4";
			default: return "pal8";
		endcase
	endfunction

	// --------------------
	// Sampling
	// --------------------
	// Mid-cycle sampling, inputs and outputs are settled at the falling edge
	always @(negedge clk) begin : sample
		entry_t head;
		entry_t fresh;
		if (rstN) begin
			cycle++;
			// Busy whenever an accepted pixel has not left yet
			if (busy !== (pending.size() != 0)) begin
				$display("ERROR busy at cycle %0d expected %0b actual %0b",
					cycle, pending.size() != 0, busy);
				protocolErrors++;
			end
			if (outValid) begin
				if (pending.size() == 0) begin
					$display("Output pixel at cycle %0d has no accepted input behind it", cycle);
					protocolErrors++;
				end else begin
					head = pending.pop_front();
					if (pixelOut !== head.exp) begin
						$display("ERROR %s pixel %0d expected %h actual %h",
							testName(head.testId), outCount, head.exp, pixelOut);
						valueErrors++;
					end
					// Two cycles plus every cycle the pixel sat frozen in stage 1
					if (cycle != head.acceptCycle + 2 + stallCount - head.stallMark) begin
						$display("ERROR %s latency of pixel %0d expected cycle %0d actual %0d",
							testName(head.testId), outCount,
							head.acceptCycle + 2 + stallCount - head.stallMark, cycle);
						timingErrors++;
					end
				end
				outCount++;
			end
			if (!pixelReady) begin
				stallCount++;
			end
			if (pixelValid && pixelReady) begin
				fresh.exp = expectedPixel(pixelIn, texFormat, clutBase, texDisable);
				fresh.testId = testIdOf(texFormat, texDisable);
				fresh.acceptCycle = cycle;
				fresh.stallMark = stallCount;
				pending.push_back(fresh);
				acceptCount++;
			end

			// APB master side
			if (psel && acceptCount == 0) begin
				$display("APB read started at cycle %0d before any pixel was accepted", cycle);
				protocolErrors++;
			end
			if (psel && pwrite) begin
				$display("APB write issued at cycle %0d by the read-only fill port", cycle);
				protocolErrors++;
			end
			if (psel && penable && pready) begin
				if (burstWords == 0) begin
					burstBase = paddr;
				end
				if (paddr != burstBase + 19'(burstWords)) begin
					$display("ERROR apbBurst word %0d expected %h actual %h",
						burstWords, burstBase + 19'(burstWords), paddr);
					protocolErrors++;
				end
				burstWords++;
			end else if (!psel && burstWords != 0) begin
				// One whole line, 4 texels or 16 colours from an aligned base
				if (!((burstWords == 4 && burstBase[1:0] == 2'b00) ||
					(burstWords == 16 && burstBase[3:0] == 4'h0))) begin
					$display("APB fill of %0d reads from %h is not one aligned cache line",
						burstWords, burstBase);
					protocolErrors++;
				end
				burstWords = 0;
			end
		end
	end

endmodule

// ==== testbench/tbTexPixel.sv ====
/*
 Texture stage testbench, LCG pixel bursts and an APB memory model
*/
module tbTexPixel;
	timeunit 1ns;
	timeprecision 100ps;
	import gpuTexPkg::*;

	localparam int clkPeriod = 4;
	localparam int numBursts = 20;
	localparam int maxBurst = 21;
	// Sixty cycles per pixel covers a texture and a CLUT fill with wait states
	localparam int watchdogCycles = numBursts * maxBurst * 60 + 2000;

	logic clk = 1'b0;
	logic rstN;
	texFormat_t texFormat;
	logic [clutAddrBits-1:0] clutBase;
	logic texDisable;
	logic pixelValid;
	pixelIn_t pixelIn;
	logic pixelReady;
	logic outValid;
	pixelOut_t pixelOut;
	logic busy;
	logic [vramAddrBits-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic pready;
	logic [15:0] prdata;
	logic pslverr;
	logic [31:0] stimState;
	logic [31:0] readyState;
	int valueErrors;
	int timingErrors;
	int protocolErrors;
	int acceptCount;
	int outCount;

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// --------------------
	// APB memory model
	// --------------------
	function automatic logic [15:0] vramWord(input logic [18:0] addr);
		logic [14:0] mixed;
		mixed = addr[14:0] ^ {addr[18:15], 11'h000} ^ 15'h1234;
		return {addr[3], mixed};
	endfunction

	assign prdata = vramWord(paddr);
	assign pslverr = 1'b0;

	// Ready in three cycles of four
	initial begin
		readyState = 32'd4;
		pready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			readyState = lcgStep(readyState);
			pready = readyState[21:20] != 2'b00;
		end
	end

	texPixelTop DUT (
		.clk(clk),
		.rstN(rstN),
		.texFormat(texFormat),
		.clutBase(clutBase),
		.texDisable(texDisable),
		.pixelValid(pixelValid),
		.pixelIn(pixelIn),
		.pixelReady(pixelReady),
		.outValid(outValid),
		.pixelOut(pixelOut),
		.busy(busy),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr)
	);

	pixelChecker uChecker (
		.clk(clk),
		.rstN(rstN),
		.texFormat(texFormat),
		.clutBase(clutBase),
		.texDisable(texDisable),
		.pixelValid(pixelValid),
		.pixelIn(pixelIn),
		.pixelReady(pixelReady),
		.outValid(outValid),
		.pixelOut(pixelOut),
		.busy(busy),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pready(pready),
		.valueErrors(valueErrors),
		.timingErrors(timingErrors),
		.protocolErrors(protocolErrors),
		.acceptCount(acceptCount),
		.outCount(outCount)
	);

	// --------------------
	// Stimulus helpers
	// --------------------
	// Texture lines in use, entries 0 and 1 share a cache slot
	function automatic logic [16:0] poolLine(input logic [2:0] k);
		case (k)
			3'd0: return 17'h0048D;
			3'd1: return 17'h0148D;
			3'd2: return 17'h00010;
			3'd3: return 17'h12345;
			3'd4: return 17'h00A00;
			3'd5: return 17'h03C07;
			3'd6: return 17'h00011;
			default: return 17'h1FFFF;
		endcase
	endfunction

	task automatic drawRandom(output logic [15:0] value);
		stimState = lcgStep(stimState);
		value = stimState[31:16];
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Holds the pixel until an edge sees ready high
	task automatic sendPixel(input pixelIn_t pix);
		logic taken;
		pixelValid = 1'b1;
		pixelIn = pix;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = pixelReady;
			@(posedge clk);
			#1;
		end
		pixelValid = 1'b0;
	endtask

	task automatic waitIdle();
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		logic [15:0] r1;
		logic [15:0] r2;
		logic [15:0] r3;
		int burstLen;
		pixelIn_t pix;
		stimState = 32'd4;
		rstN = 1'b0;
		texFormat = fmtDirect15;
		clutBase = '0;
		texDisable = 1'b0;
		pixelValid = 1'b0;
		pixelIn = '0;
		repeat (2) begin
			@(posedge clk);
		end
		#1;
		rstN = 1'b1;
		// Quiet cycles, nothing may leave the DUT yet
		idleCycles(3);
		for (int burst = 0; burst < numBursts; burst++) begin
			// Per-primitive inputs change only with the pipeline empty
			waitIdle();
			drawRandom(r1);
			texDisable = r1[1:0] == 2'd0;
			case (r1[1:0])
				2'd2: texFormat = fmtPal4;
				2'd3: texFormat = fmtPal8;
				default: texFormat = fmtDirect15;
			endcase
			clutBase = r1[15:1];
			burstLen = 6 + int'(r1[5:2]);
			for (int i = 0; i < burstLen; i++) begin
				drawRandom(r1);
				drawRandom(r2);
				drawRandom(r3);
				if (r3[2:0] > 3'd4) begin
					idleCycles(int'(r3[4:3]) + 1);
				end
				pix.scrX = r1[9:0];
				pix.scrY = r2[8:0];
				pix.r = r3[8:0];
				pix.g = r1[15:7];
				pix.b = r2[15:7];
				pix.bgMask = r3[15];
				pix.uLsb = r3[14:13];
				pix.texAddr = {poolLine(r3[12:10]), r1[11:10]};
				sendPixel(pix);
			end
		end
		waitIdle();
		idleCycles(4);
		if (acceptCount != outCount) begin
			$display("Pixel count mismatch, %0d accepted but %0d output", acceptCount, outCount);
		end
		$display("Pixels %0d, value errors %0d, latency errors %0d, protocol errors %0d",
			outCount, valueErrors, timingErrors, protocolErrors);
		if (valueErrors + timingErrors + protocolErrors == 0 && acceptCount == outCount) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog timeout, the pixel stream did not drain in %0d cycles",
			watchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
source/gpuTexPkg.sv
source/texelToIndex.sv
source/texCache.sv
source/clutCache.sv
source/pixelPipeCtrl.sv
source/cacheFillApb.sv
source/texPixelTop.sv
testbench/pixelChecker.sv
testbench/tbTexPixel.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the texture stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tbTexPixel -Mdir obj_dir -o tbTexPixel

./obj_dir/tbTexPixel > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
